/* hw/cache_pkg.sv */
package cache_pkg;

  // processor word and burst beat
  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;
  typedef logic [3:0] byte_en_t;

  // line geometry, fixed by the burst length of the RAM
  localparam int column_count = 8;
  localparam int column_index_width = 3;
  localparam int word_offset_width = 2;
  localparam int beats_per_line = 4;

  // tag RAM entry, the tag is zero extended from its real width
  typedef struct packed {
    logic dirty;
    logic valid;
    logic [29:0] tag;
  } tag_entry_t;

  // one tag RAM word, raw on the bram side and decoded for the hit logic
  typedef union packed {
    word_t raw;
    tag_entry_t entry;
  } tag_word_u;

  // write = 0 reads a line, write = 1 writes one
  typedef struct packed {
    logic write;
    logic [31:0] address;
  } burst_cmd_t;

  // one beat of a line fill, handed from the burst controller to lookup
  typedef struct packed {
    logic [column_count-1:0] column_write;
    beat_t data;
    logic tag_write;
  } fill_req_t;

endpackage

/* hw/bram.sv */
`timescale 1ns/1ps

module bram #(
  parameter int line_index_width = 8
) (
  input logic clk,
  input cache_pkg::byte_en_t write_enable,
  input logic [line_index_width-1:0] address,
  input cache_pkg::word_t data_in,
  output cache_pkg::word_t data_out
);

  cache_pkg::word_t mem[2 ** line_index_width];

  // block RAM powers up cleared, so every tag starts invalid
  initial begin
    for (int i = 0; i < 2 ** line_index_width; i++) begin
      mem[i] = '0;
    end
  end

  // byte lane writes; the read returns the word as it was before the write
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (write_enable[b]) begin
        mem[address][b*8 +: 8] <= data_in[b*8 +: 8];
      end
    end
    data_out <= mem[address];
  end

endmodule

/* hw/cache_lookup.sv */
`timescale 1ns/1ps

module cache_lookup #(
  parameter int line_index_width = 8,
  parameter int ram_address_width = 21
) (
  input logic clk,
  input logic enable,
  input cache_pkg::word_t address,
  input cache_pkg::byte_en_t write_enable,
  input cache_pkg::word_t data_in,
  input cache_pkg::fill_req_t fill,
  input logic filling,
  output logic hit,
  output logic line_dirty,
  output logic [ram_address_width-1:0] evict_line_address,
  output logic [ram_address_width-1:0] fetch_line_address,
  output cache_pkg::word_t column_data[cache_pkg::column_count],
  output cache_pkg::word_t data_out,
  output logic data_ready,
  output logic write_busy
);

  localparam int line_offset_width = cache_pkg::column_index_width
                                   + cache_pkg::word_offset_width;
  localparam int tag_width = ram_address_width - line_index_width - line_offset_width;

  // |tag|line|column|00|
  logic [cache_pkg::column_index_width-1:0] column_index;
  logic [line_index_width-1:0] line_index;
  logic [tag_width-1:0] request_tag;

  assign column_index = address[cache_pkg::word_offset_width +: cache_pkg::column_index_width];
  assign line_index = address[line_offset_width +: line_index_width];
  assign request_tag = address[line_offset_width + line_index_width +: tag_width];

  cache_pkg::word_t tag_raw;
  cache_pkg::tag_word_u tag_read;
  cache_pkg::tag_word_u tag_write;
  cache_pkg::byte_en_t tag_we;
  cache_pkg::byte_en_t column_we[cache_pkg::column_count];
  cache_pkg::word_t column_in[cache_pkg::column_count];

  // line index and tag write behind the registered bram outputs
  logic [line_index_width-1:0] read_line;
  logic tag_written;
  logic settled;
  logic write_hit;

  assign tag_read.raw = tag_raw;

  bram #(
    .line_index_width(line_index_width)
  ) tag_ram (
    .clk,
    .write_enable(tag_we),
    .address(line_index),
    .data_in(tag_write.raw),
    .data_out(tag_raw)
  );

  for (genvar i = 0; i < cache_pkg::column_count; i++) begin : column
    bram #(
      .line_index_width(line_index_width)
    ) column_ram (
      .clk,
      .write_enable(column_we[i]),
      .address(line_index),
      .data_in(column_in[i]),
      .data_out(column_data[i])
    );
  end

  always_ff @(posedge clk) begin
    read_line <= line_index;
    tag_written <= tag_we != '0;
  end

  // the tag output belongs to the held address only once it has been read for it
  assign settled = read_line == line_index && !tag_written;
  assign hit = settled && tag_read.entry.valid
            && tag_read.entry.tag == 30'(request_tag);
  assign line_dirty = tag_read.entry.valid && tag_read.entry.dirty;
  assign write_busy = enable && (!settled || (filling && write_enable != '0));

  assign evict_line_address = {
    tag_read.entry.tag[tag_width-1:0], line_index, {line_offset_width{1'b0}}
  };
  assign fetch_line_address = {request_tag, line_index, {line_offset_width{1'b0}}};

  assign data_out = column_data[column_index];
  assign data_ready = enable && hit && write_enable == '0;
  assign write_hit = enable && hit && write_enable != '0 && !filling;

  always_comb begin
    tag_we = '0;
    tag_write.raw = '0;
    for (int i = 0; i < cache_pkg::column_count; i++) begin
      column_we[i] = '0;
      column_in[i] = data_in;
    end

    if (filling) begin
      // even columns take the low half of a beat, odd columns the high half
      for (int i = 0; i < cache_pkg::column_count; i++) begin
        column_we[i] = {4{fill.column_write[i]}};
        column_in[i] = fill.data[(i % 2) * 32 +: 32];
      end
      if (fill.tag_write) begin
        tag_we = '1;
        tag_write.entry.valid = 1'b1;
        tag_write.entry.dirty = 1'b0;
        tag_write.entry.tag = 30'(request_tag);
      end
    end else if (write_hit) begin
      column_we[column_index] = write_enable;
      // the tag is only rewritten when the line turns dirty
      if (!tag_read.entry.dirty) begin
        tag_we = '1;
        tag_write.entry.valid = 1'b1;
        tag_write.entry.dirty = 1'b1;
        tag_write.entry.tag = tag_read.entry.tag;
      end
    end
  end

endmodule

/* hw/cache_burst_ctrl.sv */
`timescale 1ns/1ps

module cache_burst_ctrl #(
  parameter int ram_address_width = 21,
  parameter int command_interval_cycles = 13
) (
  input logic clk,
  input logic rst_n,
  input logic enable,
  input logic hit,
  input logic line_dirty,
  input logic write_busy,
  input logic [ram_address_width-1:0] evict_line_address,
  input logic [ram_address_width-1:0] fetch_line_address,
  input cache_pkg::word_t column_data[cache_pkg::column_count],
  output cache_pkg::fill_req_t fill,
  output logic filling,
  output logic busy,
  output cache_pkg::burst_cmd_t cmd,
  output logic cmd_en,
  output cache_pkg::beat_t wr_data,
  input cache_pkg::beat_t rd_data,
  input logic rd_valid
);

  localparam int counter_width = $clog2(command_interval_cycles + 1);
  localparam int beat_index_width = $clog2(cache_pkg::beats_per_line);
  localparam logic [beat_index_width-1:0] last_beat =
    beat_index_width'(cache_pkg::beats_per_line - 1);

  typedef enum logic [2:0] {
    state_idle,
    state_write_beats,
    state_write_wait,
    state_read_wait,
    state_read_beats,
    state_tag_update,
    state_fill_done
  } state_t;

  state_t state;
  logic [counter_width-1:0] interval_count;
  logic [beat_index_width-1:0] beat_count;
  logic miss;

  // a miss is only trusted once lookup has settled on the held address
  assign miss = enable && !hit && !write_busy;
  assign busy = (enable && !hit) || write_busy || interval_count != '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= state_idle;
      interval_count <= '0;
      beat_count <= '0;
      cmd_en <= 1'b0;
      filling <= 1'b0;
      fill.column_write <= '0;
      fill.tag_write <= 1'b0;
    end else begin
      // minimum spacing between two commands
      if (interval_count != '0) begin
        interval_count <= interval_count - 1'b1;
      end

      unique case (state)
        state_idle: begin
          if (miss && interval_count == '0) begin
            cmd_en <= 1'b1;
            interval_count <= counter_width'(command_interval_cycles);
            if (line_dirty) begin
              // evict first, beat 0 goes out with the command
              cmd.write <= 1'b1;
              cmd.address <= 32'(evict_line_address);
              wr_data <= {column_data[1], column_data[0]};
              beat_count <= 1;
              state <= state_write_beats;
            end else begin
              cmd.write <= 1'b0;
              cmd.address <= 32'(fetch_line_address);
              filling <= 1'b1;
              state <= state_read_wait;
            end
          end
        end

        state_write_beats: begin
          cmd_en <= 1'b0;
          wr_data <= {column_data[{beat_count, 1'b1}], column_data[{beat_count, 1'b0}]};
          beat_count <= beat_count + 1'b1;
          if (beat_count == last_beat) begin
            state <= state_write_wait;
          end
        end

        state_write_wait: begin
          if (interval_count == '0) begin
            cmd_en <= 1'b1;
            cmd.write <= 1'b0;
            cmd.address <= 32'(fetch_line_address);
            interval_count <= counter_width'(command_interval_cycles);
            filling <= 1'b1;
            state <= state_read_wait;
          end
        end

        state_read_wait: begin
          cmd_en <= 1'b0;
          // latency ends with the first valid beat
          if (rd_valid) begin
            fill.data <= rd_data;
            fill.column_write <= cache_pkg::column_count'(2'b11);
            beat_count <= 1;
            state <= state_read_beats;
          end
        end

        state_read_beats: begin
          if (rd_valid) begin
            fill.data <= rd_data;
            fill.column_write <= cache_pkg::column_count'(2'b11) << (2 * beat_count);
            beat_count <= beat_count + 1'b1;
            if (beat_count == last_beat) begin
              state <= state_tag_update;
            end
          end
        end

        state_tag_update: begin
          // last beat lands in the columns this cycle, the tag follows
          fill.column_write <= '0;
          fill.tag_write <= 1'b1;
          state <= state_fill_done;
        end

        state_fill_done: begin
          fill.tag_write <= 1'b0;
          filling <= 1'b0;
          state <= state_idle;
        end

        default: begin
          state <= state_idle;
        end
      endcase
    end
  end

endmodule

/* hw/cache.sv */
`timescale 1ns/1ps

module cache #(
  parameter int line_index_width = 8,
  parameter int ram_address_width = 21,
  parameter int command_interval_cycles = 13
) (
  input logic clk,
  input logic rst_n,
  input logic enable,
  input cache_pkg::word_t address,
  input cache_pkg::byte_en_t write_enable,
  input cache_pkg::word_t data_in,
  output cache_pkg::word_t data_out,
  output logic data_ready,
  output logic busy,
  // burst RAM controller side
  output cache_pkg::burst_cmd_t br_cmd,
  output logic br_cmd_en,
  output cache_pkg::beat_t br_wr_data,
  input cache_pkg::beat_t br_rd_data,
  input logic br_rd_data_valid
);

  logic hit;
  logic line_dirty;
  logic write_busy;
  logic filling;
  logic [ram_address_width-1:0] evict_line_address;
  logic [ram_address_width-1:0] fetch_line_address;
  cache_pkg::word_t column_data[cache_pkg::column_count];
  cache_pkg::fill_req_t fill;

  cache_lookup #(
    .line_index_width(line_index_width),
    .ram_address_width(ram_address_width)
  ) lookup (
    .clk,
    .enable,
    .address,
    .write_enable,
    .data_in,
    .fill,
    .filling,
    .hit,
    .line_dirty,
    .evict_line_address,
    .fetch_line_address,
    .column_data,
    .data_out,
    .data_ready,
    .write_busy
  );

  cache_burst_ctrl #(
    .ram_address_width(ram_address_width),
    .command_interval_cycles(command_interval_cycles)
  ) burst_ctrl (
    .clk,
    .rst_n,
    .enable,
    .hit,
    .line_dirty,
    .write_busy,
    .evict_line_address,
    .fetch_line_address,
    .column_data,
    .fill,
    .filling,
    .busy,
    .cmd(br_cmd),
    .cmd_en(br_cmd_en),
    .wr_data(br_wr_data),
    .rd_data(br_rd_data),
    .rd_valid(br_rd_data_valid)
  );

endmodule

/* sim/burst_ram_model.sv */
`timescale 1ns/1ps

module burst_ram_model (
  input logic clk,
  input cache_pkg::burst_cmd_t cmd,
  input logic cmd_en,
  input cache_pkg::beat_t wr_data,
  output cache_pkg::beat_t rd_data,
  output logic rd_valid
);

  // sparse store keyed by byte address, unwritten words follow a pattern
  cache_pkg::word_t mem[int unsigned];

  // write-back beats as seen on the bus, read by the testbench
  cache_pkg::word_t write_addresses[64];
  cache_pkg::beat_t write_beats[64];
  int write_beat_count = 0;
  int command_count = 0;
  // read commands so far, and that count as each write-back beat arrived
  int read_command_count = 0;
  int reads_before_beat[64];

  int write_left = 0;
  int read_left = 0;
  int unsigned read_delay = 0;
  cache_pkg::word_t write_address;
  cache_pkg::word_t read_address;

  function automatic cache_pkg::word_t load(input cache_pkg::word_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return addr ^ 32'hc0de_0000;
  endfunction

  function automatic void store_beat(input cache_pkg::word_t addr, input cache_pkg::beat_t beat);
    mem[addr] = beat[31:0];
    mem[addr + 4] = beat[63:32];
    write_addresses[write_beat_count] = addr;
    write_beats[write_beat_count] = beat;
    reads_before_beat[write_beat_count] = read_command_count;
    write_beat_count++;
  endfunction

  initial begin
    rd_valid = 1'b0;
    rd_data = '0;
  end

  always @(posedge clk) begin
    rd_valid <= 1'b0;
    // beats 1 to 3 of a write follow the command on consecutive cycles
    if (write_left > 0) begin
      store_beat(write_address, wr_data);
      write_address = write_address + 8;
      write_left--;
    end
    if (cmd_en === 1'b1) begin
      command_count++;
      if (cmd.write) begin
        store_beat(cmd.address, wr_data);
        write_address = cmd.address + 8;
        write_left = 3;
      end else begin
        read_command_count++;
        read_address = cmd.address;
        read_delay = 6 + ($urandom % 8);
        read_left = 4;
      end
    end else if (read_left > 0) begin
      if (read_delay > 0) begin
        read_delay--;
      end else begin
        rd_valid <= 1'b1;
        rd_data <= {load(read_address + 4), load(read_address)};
        read_address = read_address + 8;
        read_left--;
      end
    end
  end

endmodule

/* sim/cache_properties.sv */
`timescale 1ns/1ps

module cache_properties #(
  parameter int command_interval_cycles = 13
) (
  input logic clk,
  input logic rst_n,
  input logic enable,
  input logic hit,
  input logic busy,
  input logic cmd_en
);

  // cycles since the last command, saturating
  int since_cmd;
  // assertion failures so far
  int failures = 0;

  always @(posedge clk) begin
    if (!rst_n) begin
      since_cmd <= 1000;
    end else if (cmd_en) begin
      since_cmd <= 1;
    end else if (since_cmd < 1000) begin
      since_cmd <= since_cmd + 1;
    end
  end

  cmd_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_en |-> since_cmd >= command_interval_cycles)
    else begin
      $error("burst commands closer than the minimum interval");
      failures++;
    end

  cmd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_en |=> !cmd_en)
    else begin
      $error("burst command enable held longer than one cycle");
      failures++;
    end

  // an enabled request that hits is never busy
  ready_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (enable && hit) |-> !busy)
    else begin
      $error("read result offered while busy");
      failures++;
    end

endmodule

bind cache_burst_ctrl cache_properties #(
  .command_interval_cycles(command_interval_cycles)
) props (
  .clk(clk),
  .rst_n(rst_n),
  .enable(enable),
  .hit(hit),
  .busy(busy),
  .cmd_en(cmd_en)
);

/* sim/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;

  localparam int line_index_width = 8;
  localparam int ram_address_width = 21;
  localparam int command_interval_cycles = 13;
  localparam int wait_limit = 300;

  logic clk;
  logic rst_n;
  logic enable;
  cache_pkg::word_t address;
  cache_pkg::byte_en_t write_enable;
  cache_pkg::word_t data_in;
  cache_pkg::word_t data_out;
  logic data_ready;
  logic busy;
  cache_pkg::burst_cmd_t br_cmd;
  logic br_cmd_en;
  cache_pkg::beat_t br_wr_data;
  cache_pkg::beat_t br_rd_data;
  logic br_rd_data_valid;

  cache #(
    .line_index_width(line_index_width),
    .ram_address_width(ram_address_width),
    .command_interval_cycles(command_interval_cycles)
  ) UUT (
    .clk, .rst_n, .enable, .address, .write_enable, .data_in,
    .data_out, .data_ready, .busy,
    .br_cmd, .br_cmd_en, .br_wr_data, .br_rd_data, .br_rd_data_valid
  );

  burst_ram_model ram_model (
    .clk,
    .cmd(br_cmd),
    .cmd_en(br_cmd_en),
    .wr_data(br_wr_data),
    .rd_data(br_rd_data),
    .rd_valid(br_rd_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_with(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input cache_pkg::word_t actual, input cache_pkg::word_t expected,
                            input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, what, expected, actual);
      stop_with("word mismatch");
    end
  endtask

  task automatic check_beat(input cache_pkg::beat_t actual, input cache_pkg::beat_t expected,
                            input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, what, expected, actual);
      stop_with("beat mismatch");
    end
  endtask

  // handshake rule and bound assertions, sampled before the edge updates
  always @(posedge clk) begin
    if (rst_n === 1'b1) begin
      if (data_ready === 1'b1 && busy !== 1'b0) begin
        stop_with("data_ready is high while busy is high");
      end
      if (UUT.burst_ctrl.props.failures != 0) begin
        stop_with("a bound assertion on the burst port failed");
      end
    end
  end

  // requests start and end on a falling edge
  task automatic read_word(input cache_pkg::word_t addr, output cache_pkg::word_t value);
    int cycles;
    cycles = 0;
    @(negedge clk);
    enable = 1'b1;
    address = addr;
    write_enable = '0;
    data_in = '0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > wait_limit) begin
        stop_with("timeout waiting for data_ready on a read");
      end
    end while (!data_ready);
    value = data_out;
    @(negedge clk);
    enable = 1'b0;
  endtask

  task automatic write_word(input cache_pkg::word_t addr, input cache_pkg::word_t data,
                            input cache_pkg::byte_en_t mask);
    int cycles;
    cycles = 0;
    @(negedge clk);
    enable = 1'b1;
    address = addr;
    write_enable = mask;
    data_in = data;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > wait_limit) begin
        stop_with("timeout waiting for busy to fall on a write");
      end
    end while (busy);
    // the write lands on the next rising edge
    @(posedge clk);
    @(negedge clk);
    enable = 1'b0;
    write_enable = '0;
  endtask

  initial begin
    int fd;
    int code;
    int wb_index;
    int commands_before;
    int reads_before;
    logic [63:0] op;
    logic [1023:0] rest;
    cache_pkg::word_t addr;
    cache_pkg::word_t data;
    cache_pkg::word_t mask;
    cache_pkg::word_t expected;
    cache_pkg::word_t value;

    void'($urandom(32'h0a0e_27b7));
    rst_n = 1'b0;
    enable = 1'b0;
    address = '0;
    write_enable = '0;
    data_in = '0;
    wb_index = 0;
    reads_before = 0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("sim/cache_cases.txt", "r");
    if (fd == 0) begin
      stop_with("cannot open sim/cache_cases.txt");
    end

    while (1) begin
      code = $fscanf(fd, " %s", op);
      if (code != 1) begin
        break;
      end
      if (op == "#") begin
        code = $fgets(rest, fd);
        continue;
      end
      code = $fscanf(fd, " %h %h %h %h", addr, data, mask, expected);
      if (code != 4) begin
        stop_with("malformed line in case file");
      end
      if (op == "rd") begin
        // an eviction caused by this read must finish before its fill read
        reads_before = ram_model.read_command_count;
        read_word(addr, value);
        check_word(value, expected, "read");
      end else if (op == "rh") begin
        // must hit, so no burst command may appear
        commands_before = ram_model.command_count;
        read_word(addr, value);
        check_word(value, expected, "read hit");
        check_word(ram_model.command_count, commands_before, "burst commands on a hit");
      end else if (op == "wr") begin
        write_word(addr, data, mask[3:0]);
      end else if (op == "wb") begin
        if (wb_index >= ram_model.write_beat_count) begin
          stop_with("expected write-back beat never appeared on the burst port");
        end
        check_word(ram_model.write_addresses[wb_index], addr, "write-back address");
        check_beat(ram_model.write_beats[wb_index], {data, expected}, "write-back beat");
        check_word(ram_model.reads_before_beat[wb_index], reads_before,
                   "read commands issued before the write-back beat");
        wb_index++;
      end else begin
        stop_with("unknown operation in case file");
      end
    end
    $fclose(fd);

    if (wb_index != ram_model.write_beat_count) begin
      $display("%0d write-back beats seen, %0d expected",
               ram_model.write_beat_count, wb_index);
      $display("SIMULATION FAILED");
      $fatal(1, "unexpected write-back beats");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

/* sim/cache_cases.txt */
# op addr data mask expected, all hex except op
# rd read, rh read that must hit, wr masked write, wb write-back beat (data high, expected low)
rd 00000100 00000000 0 c0de0100
rh 00000104 00000000 0 c0de0104
rh 0000011c 00000000 0 c0de011c
wr 00000108 11223344 3 00000000
rh 00000108 00000000 0 c0de3344
wr 00000110 aabbccdd f 00000000
wr 0000010c 55667788 c 00000000
rh 0000010c 00000000 0 5566010c
rh 00000110 00000000 0 aabbccdd
# neighboring lines 9, 7 and 10 leave line 8 alone
rd 00000120 00000000 0 c0de0120
rd 000000e0 00000000 0 c0de00e0
rd 00000140 00000000 0 c0de0140
rh 00000100 00000000 0 c0de0100
rh 000000e4 00000000 0 c0de00e4
rh 00000124 00000000 0 c0de0124
# tag 1 on line 8 evicts the dirty line
rd 00002100 00000000 0 c0de2100
wb 00000100 c0de0104 0 c0de0100
wb 00000108 5566010c 0 c0de3344
wb 00000110 c0de0114 0 aabbccdd
wb 00000118 c0de011c 0 c0de0118
rh 00002104 00000000 0 c0de2104
# evicted data now comes back from the model
rd 00000108 00000000 0 c0de3344
rh 0000010c 00000000 0 5566010c
rh 00000110 00000000 0 aabbccdd
rh 00000100 00000000 0 c0de0100
rd 00002104 00000000 0 c0de2104
rh 00000144 00000000 0 c0de0144

/* list.f */
hw/cache_pkg.sv
hw/bram.sv
hw/cache_lookup.sv
hw/cache_burst_ctrl.sv
hw/cache.sv
sim/burst_ram_model.sv
sim/cache_properties.sv
sim/tb_cache.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cache
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS ?= --binary --assert --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
